// ==== project.f ====
+incdir+design
design/emib_pkg.sv
design/node_cfg_pkg.sv
design/cfg_tag_if.sv
design/cfg_wr_if.sv
design/cfg_read_sequencer.sv
design/cfg_read_tracker.sv
design/node_identity_regs.sv
design/layer_timing_regs.sv
design/cfg_loader_top.sv
test/emib_ram_model.sv
test/tb_cfg_loader.sv

// ==== Bender.yml ====
package:
  name: cfg_loader

sources:
  - include_dirs:
      - design
    files:
      - design/emib_pkg.sv
      - design/node_cfg_pkg.sv
      - design/cfg_tag_if.sv
      - design/cfg_wr_if.sv
      - design/cfg_read_sequencer.sv
      - design/cfg_read_tracker.sv
      - design/node_identity_regs.sv
      - design/layer_timing_regs.sv
      - design/cfg_loader_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/emib_ram_model.sv
      - test/tb_cfg_loader.sv

// ==== test/tb_cfg_loader.sv ====
// testbench for the config loader, drives the start inputs and checks reads and fields against EMIB
`default_nettype none

`include "cfg_loader_cfg.svh"

module tb_cfg_loader import emib_pkg::*, node_cfg_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 400;   // three loads of ~30 cycles plus idle gaps

	logic i_clk;
	logic i_rst_n;
	logic i_read_flash_done;
	logic i_config_flag;
	emib_word_t emib_data;
	emib_addr_t o_emib_addr;
	logic o_rd_ram_en;
	logic o_cfg_done;
	ip_t o_local_ip;
	mac_t o_local_mac;
	emib_word_t o_device_type;
	emib_word_t o_device_state;
	time_t o_up_macro_cycle_time;
	time_t o_up_real_cycle_time;
	time_t o_up_send_offset;
	len_t o_up_data_len_local;
	len_t o_up_data_len_net;
	time_t o_down_macro_cycle_time;
	time_t o_down_real_cycle_time;
	time_t o_down_send_offset;
	len_t o_down_data_len_local;
	len_t o_down_data_len_net;

	emib_addr_t addr_order [$];    // expected address of each read
	int read_idx = 0;
	int bursts_done = 0;
	int cycle_cnt = 0;

	cfg_loader_top DUT (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_read_flash_done (i_read_flash_done),
		.i_config_flag (i_config_flag),
		.i_emib_data (emib_data),
		.o_emib_addr (o_emib_addr),
		.o_rd_ram_en (o_rd_ram_en),
		.o_cfg_done (o_cfg_done),
		.o_local_ip (o_local_ip),
		.o_local_mac (o_local_mac),
		.o_device_type (o_device_type),
		.o_device_state (o_device_state),
		.o_up_macro_cycle_time (o_up_macro_cycle_time),
		.o_up_real_cycle_time (o_up_real_cycle_time),
		.o_up_send_offset (o_up_send_offset),
		.o_up_data_len_local (o_up_data_len_local),
		.o_up_data_len_net (o_up_data_len_net),
		.o_down_macro_cycle_time (o_down_macro_cycle_time),
		.o_down_real_cycle_time (o_down_real_cycle_time),
		.o_down_send_offset (o_down_send_offset),
		.o_down_data_len_local (o_down_data_len_local),
		.o_down_data_len_net (o_down_data_len_net)
	);

	emib_ram_model ram (
		.i_clk (i_clk),
		.i_rd_en (o_rd_ram_en),
		.i_addr (o_emib_addr),
		.o_data (emib_data)
	);

	// ************************************************************************
	// reporting and helpers
	// ************************************************************************

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("Checks failed");
		$fatal(1, "Fail %s expected 0x%0h actual 0x%0h", name, exp, act);
	endtask

	task automatic abort_run(input string msg);
		$display("Checks failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
		assert (act === exp)
		else report_mismatch(name, exp, act);
	endtask

	task automatic next_cycle();
		@(posedge i_clk);
		#2;                    // drive and look after the edge settles
	endtask

	task automatic add_addr_run(input int first, input int count);
		for (int i = 0; i < count; i++)
			addr_order.push_back(emib_addr_t'(first + i));
	endtask

	// stored length counts bytes, register counts 16-bit words
	function automatic len_t bytes_to_words(input emib_word_t w);
		return {1'b0, w[15:1]};
	endfunction

	task automatic check_reset_values();
		compare("o_rd_ram_en", o_rd_ram_en, 0);
		compare("o_cfg_done", o_cfg_done, 0);
		compare("o_local_ip", o_local_ip, 0);
		compare("o_local_mac", o_local_mac, 0);
		compare("o_device_type", o_device_type, 0);
		compare("o_device_state", o_device_state, 0);
		compare("o_up_macro_cycle_time", o_up_macro_cycle_time, `CFG_MACRO_DEFAULT);
		compare("o_up_real_cycle_time", o_up_real_cycle_time, `CFG_REAL_DEFAULT);
		compare("o_up_send_offset", o_up_send_offset, `CFG_SEND_DEFAULT);
		compare("o_up_data_len_local", o_up_data_len_local, `CFG_UP_LEN_LOCAL_DEFAULT);
		compare("o_up_data_len_net", o_up_data_len_net, 0);
		compare("o_down_macro_cycle_time", o_down_macro_cycle_time, `CFG_MACRO_DEFAULT);
		compare("o_down_real_cycle_time", o_down_real_cycle_time, `CFG_REAL_DEFAULT);
		compare("o_down_send_offset", o_down_send_offset, `CFG_SEND_DEFAULT);
		compare("o_down_data_len_local", o_down_data_len_local, 0);
		compare("o_down_data_len_net", o_down_data_len_net, 0);
	endtask

	// first word read sits on top
	task automatic check_loaded_fields();
		compare("o_local_ip", o_local_ip, {ram.mem['h26], ram.mem['h27]});
		compare("o_local_mac", o_local_mac, {ram.mem['h2C], ram.mem['h2D], ram.mem['h2E]});
		compare("o_device_type", o_device_type, ram.mem['h33]);
		compare("o_device_state", o_device_state, ram.mem['h34]);
		compare("o_up_macro_cycle_time", o_up_macro_cycle_time, {ram.mem['h51], ram.mem['h52]});
		compare("o_up_real_cycle_time", o_up_real_cycle_time, {ram.mem['h53], ram.mem['h54]});
		compare("o_up_send_offset", o_up_send_offset, {ram.mem['h57], ram.mem['h58]});
		compare("o_up_data_len_local", o_up_data_len_local, bytes_to_words(ram.mem['h59]));
		compare("o_up_data_len_net", o_up_data_len_net, bytes_to_words(ram.mem['h5C]));
		compare("o_down_macro_cycle_time", o_down_macro_cycle_time,
			{ram.mem['h5D], ram.mem['h5E]});
		compare("o_down_real_cycle_time", o_down_real_cycle_time, {ram.mem['h5F], ram.mem['h60]});
		compare("o_down_send_offset", o_down_send_offset, {ram.mem['h61], ram.mem['h62]});
		compare("o_down_data_len_local", o_down_data_len_local, bytes_to_words(ram.mem['h63]));
		compare("o_down_data_len_net", o_down_data_len_net, bytes_to_words(ram.mem['h66]));
	endtask

	// ************************************************************************
	// clock, watchdog and monitors
	// ************************************************************************

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("Checks failed");
			$fatal(1, "timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	// burst length, address order, parked address
	always @(negedge i_clk)
	begin
		if (o_rd_ram_en)
		begin
			assert (read_idx < `CFG_NUM_READS)
			else abort_run("read burst runs past the last table entry");
			compare("o_emib_addr", o_emib_addr, addr_order[read_idx]);
			read_idx = read_idx + 1;
		end
		else
		begin
			if (read_idx != 0)
			begin
				assert (read_idx == `CFG_NUM_READS)
				else abort_run("read burst ended before all words were read");
				bursts_done = bursts_done + 1;
			end
			read_idx = 0;
			compare("o_emib_addr", o_emib_addr, 0);
		end
	end

	a_start_gated: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_rd_ram_en) |-> $past(i_read_flash_done && i_config_flag, 2))
		else abort_run("read burst started without both start inputs high");

	a_done_after_last: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$rose(o_cfg_done) |-> $past(o_rd_ram_en, 4) && !$past(o_rd_ram_en, 3))
		else abort_run("done rose before the last read was captured");

	a_done_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!$fell(o_cfg_done))
		else abort_run("done dropped without a reset");

	// ************************************************************************
	// stimulus
	// ************************************************************************

	initial
	begin
		i_rst_n = 1'b0;
		i_read_flash_done = 1'b0;
		i_config_flag = 1'b0;
		add_addr_run('h26, 2);   // IP
		add_addr_run('h2C, 3);   // MAC
		add_addr_run('h33, 2);   // type, state
		add_addr_run('h51, 4);
		add_addr_run('h57, 3);
		add_addr_run('h5C, 1);
		add_addr_run('h5D, 7);
		add_addr_run('h66, 1);
		repeat (4) @(posedge i_clk);
		#2;
		i_rst_n = 1'b1;
		check_reset_values();

		// flash copy done but no request yet
		i_read_flash_done = 1'b1;
		repeat (10)
		begin
			next_cycle();
			compare("o_rd_ram_en", o_rd_ram_en, 0);
		end
		i_config_flag = 1'b1;
		while (!o_rd_ram_en)
			next_cycle();
		i_read_flash_done = 1'b0;   // single load only
		i_config_flag = 1'b0;
		while (!o_cfg_done)
			next_cycle();
		check_loaded_fields();
		repeat (8)
			next_cycle();
		compare("o_cfg_done", o_cfg_done, 1);
		assert (bursts_done == 1)
		else abort_run("first load did not issue exactly one read burst");

		// new contents, start held so the loader runs twice
		ram.fill();
		i_read_flash_done = 1'b1;
		i_config_flag = 1'b1;
		while (!o_rd_ram_en)
			next_cycle();
		while (o_rd_ram_en)
			next_cycle();
		repeat (`CFG_RD_LATENCY)
			next_cycle();
		check_loaded_fields();
		while (!o_rd_ram_en)
			next_cycle();
		i_read_flash_done = 1'b0;
		i_config_flag = 1'b0;
		while (o_rd_ram_en)
			next_cycle();
		repeat (`CFG_RD_LATENCY)
			next_cycle();
		check_loaded_fields();

		repeat (10)
			next_cycle();
		assert (bursts_done == 3)
		else abort_run("reload did not give three read bursts in total");
		compare("o_cfg_done", o_cfg_done, 1);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/emib_ram_model.sv ====
// behavioural EMIB memory for the loader testbench, seeded random contents and fixed read latency
`default_nettype none

`include "cfg_loader_cfg.svh"

module emib_ram_model import emib_pkg::*; (
	input wire i_clk,
	input wire i_rd_en,
	input emib_addr_t i_addr,
	output emib_word_t o_data
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int DEPTH = 256;
	localparam int LAT = `CFG_RD_LATENCY;

	emib_word_t mem [DEPTH];          // read by the testbench for expected values
	emib_word_t pipe [LAT];
	integer seed;

	// new contents on every call, the seed carries on
	task automatic fill();
		for (int a = 0; a < DEPTH; a++)
			mem[a] = emib_word_t'($random(seed));
	endtask

	initial
	begin
		seed = 57;
		for (int i = 0; i < LAT; i++)
			pipe[i] = '0;
		fill();
	end

	// address latched with the enable, word comes out LAT cycles later
	always @(posedge i_clk)
	begin
		pipe[0] <= i_rd_en ? mem[i_addr[7:0]] : '0;
		for (int i = 1; i < LAT; i++)
			pipe[i] <= pipe[i-1];
	end

	assign o_data = pipe[LAT-1];

endmodule

`default_nettype wire

// ==== design/cfg_loader_top.sv ====
// configuration loader top level, reads node setup from EMIB and presents it on plain ports
`default_nettype none

module cfg_loader_top import emib_pkg::*, node_cfg_pkg::*; (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_read_flash_done,
	input wire i_config_flag,
	input emib_word_t i_emib_data,

	output emib_addr_t o_emib_addr,
	output logic o_rd_ram_en,
	output logic o_cfg_done,

	output ip_t o_local_ip,
	output mac_t o_local_mac,
	output emib_word_t o_device_type,
	output emib_word_t o_device_state,

	output time_t o_up_macro_cycle_time,
	output time_t o_up_real_cycle_time,
	output time_t o_up_send_offset,
	output len_t o_up_data_len_local,
	output len_t o_up_data_len_net,

	output time_t o_down_macro_cycle_time,
	output time_t o_down_real_cycle_time,
	output time_t o_down_send_offset,
	output len_t o_down_data_len_local,
	output len_t o_down_data_len_net
);

	cfg_tag_if tag_bus ();    // sequencer to tracker
	cfg_wr_if wr_bus ();      // tracker to all register blocks

	cfg_read_sequencer u_seq (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_read_flash_done (i_read_flash_done),
		.i_config_flag (i_config_flag),
		.o_emib_addr (o_emib_addr),
		.o_rd_ram_en (o_rd_ram_en),
		.tag (tag_bus)
	);

	cfg_read_tracker u_trk (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_emib_data (i_emib_data),
		.tag (tag_bus),
		.wr (wr_bus),
		.o_cfg_done (o_cfg_done)
	);

	// ************************************************************************
	// field registers
	// ************************************************************************

	node_identity_regs u_ident (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.wr (wr_bus),
		.o_local_ip (o_local_ip),
		.o_local_mac (o_local_mac),
		.o_device_type (o_device_type),
		.o_device_state (o_device_state)
	);

	layer_timing_regs #(.LAYER(L_UP)) u_up (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.wr (wr_bus),
		.o_macro_cycle_time (o_up_macro_cycle_time),
		.o_real_cycle_time (o_up_real_cycle_time),
		.o_send_offset (o_up_send_offset),
		.o_data_len_local (o_up_data_len_local),
		.o_data_len_net (o_up_data_len_net)
	);

	layer_timing_regs #(.LAYER(L_DOWN)) u_down (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.wr (wr_bus),
		.o_macro_cycle_time (o_down_macro_cycle_time),
		.o_real_cycle_time (o_down_real_cycle_time),
		.o_send_offset (o_down_send_offset),
		.o_data_len_local (o_down_data_len_local),
		.o_data_len_net (o_down_data_len_net)
	);

endmodule

`default_nettype wire

// ==== design/layer_timing_regs.sv ====
// cycle times, send offset and data lengths of one network layer, selected by LAYER
`default_nettype none

`include "cfg_loader_cfg.svh"

module layer_timing_regs import node_cfg_pkg::*; #(
	parameter layer_e LAYER = L_UP      // L_UP or L_DOWN
) (
	input wire i_clk,
	input wire i_rst_n,
	cfg_wr_if.dst wr,
	output time_t o_macro_cycle_time,
	output time_t o_real_cycle_time,
	output time_t o_send_offset,
	output len_t o_data_len_local,
	output len_t o_data_len_net
);

	localparam int W = `CFG_WORD_SZ;

	// only the up layer has a nonzero local length at reset
	localparam len_t LEN_LOCAL_RST = (LAYER == L_UP) ? len_t'(`CFG_UP_LEN_LOCAL_DEFAULT) : len_t'(0);

	logic layer_wr;
	int half;              // 1 selects the upper half

	assign layer_wr = wr.wr_en && (wr.layer == LAYER);
	assign half = 1 - int'(wr.word_idx);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_macro_cycle_time <= `CFG_MACRO_DEFAULT;
			o_real_cycle_time <= `CFG_REAL_DEFAULT;
			o_send_offset <= `CFG_SEND_DEFAULT;
			o_data_len_local <= LEN_LOCAL_RST;
			o_data_len_net <= '0;
		end
		else if (layer_wr)
		begin
			case (wr.field)
				F_MACRO: o_macro_cycle_time[W*half +: W] <= wr.data;
				F_REAL: o_real_cycle_time[W*half +: W] <= wr.data;
				F_SEND: o_send_offset[W*half +: W] <= wr.data;
				// stored in bytes, kept in 16-bit words
				F_LEN_LOCAL: o_data_len_local <= wr.data >> 1;
				F_LEN_NET: o_data_len_net <= wr.data >> 1;
				default: ;
			endcase
		end
	end

	a_idx_two_words: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		layer_wr |-> wr.word_idx <= 2'd1)
		else $error("layer %s got word index %0d", LAYER.name(), wr.word_idx);

endmodule

`default_nettype wire

// ==== design/node_identity_regs.sv ====
// node IP, MAC, device type and device state registers, loaded word by word from the tracker
`default_nettype none

`include "cfg_loader_cfg.svh"

module node_identity_regs import emib_pkg::*, node_cfg_pkg::*; (
	input wire i_clk,
	input wire i_rst_n,
	cfg_wr_if.dst wr,
	output ip_t o_local_ip,
	output mac_t o_local_mac,
	output emib_word_t o_device_type,
	output emib_word_t o_device_state
);

	localparam int IP_WORDS = $bits(ip_t) / `CFG_WORD_SZ;
	localparam int MAC_WORDS = $bits(mac_t) / `CFG_WORD_SZ;

	logic node_wr;

	// words making up each field
	function automatic int field_words(field_e f);
		case (f)
			F_IP: return IP_WORDS;
			F_MAC: return MAC_WORDS;
			default: return 1;
		endcase
	endfunction

	assign node_wr = wr.wr_en && (wr.layer == L_NODE);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_local_ip <= '0;
			o_local_mac <= '0;
			o_device_type <= '0;
			o_device_state <= '0;
		end
		else if (node_wr)
		begin
			case (wr.field)
				// word 0 goes to the top slot
				F_IP: o_local_ip[`CFG_WORD_SZ*(IP_WORDS-1-int'(wr.word_idx)) +: `CFG_WORD_SZ]
					<= wr.data;
				F_MAC: o_local_mac[`CFG_WORD_SZ*(MAC_WORDS-1-int'(wr.word_idx)) +: `CFG_WORD_SZ]
					<= wr.data;
				F_TYPE: o_device_type <= wr.data;
				F_STATE: o_device_state <= wr.data;
				default: ;   // timing fields not held here
			endcase
		end
	end

	a_idx_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		node_wr |-> int'(wr.word_idx) < field_words(wr.field))
		else $error("word index %0d out of range for field %s", wr.word_idx, wr.field.name());

endmodule

`default_nettype wire

// ==== design/cfg_read_tracker.sv ====
// delay line that lines each read tag up with its returned EMIB word and flags load done
`default_nettype none

`include "cfg_loader_cfg.svh"

module cfg_read_tracker import emib_pkg::*, node_cfg_pkg::*; (
	input wire i_clk,
	input wire i_rst_n,
	input emib_word_t i_emib_data,
	cfg_tag_if.dst tag,
	cfg_wr_if.src wr,
	output logic o_cfg_done
);

	localparam int LAT = `CFG_RD_LATENCY;

	logic [LAT-1:0] vld_sr;
	logic [LAT-1:0] last_sr;
	layer_e layer_sr [LAT];
	field_e field_sr [LAT];
	word_idx_t idx_sr [LAT];

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			vld_sr <= '0;
			last_sr <= '0;
			o_cfg_done <= 1'b0;
		end
		else
		begin
			vld_sr <= {vld_sr[LAT-2:0], tag.valid};
			last_sr <= {last_sr[LAT-2:0], tag.last};
			if (vld_sr[LAT-1] && last_sr[LAT-1])
				o_cfg_done <= 1'b1;   // sticky until reset
		end
	end

	// tag payload follows the valid bits
	always_ff @(posedge i_clk)
	begin
		layer_sr[0] <= tag.layer;
		field_sr[0] <= tag.field;
		idx_sr[0] <= tag.word_idx;
		for (int i = 1; i < LAT; i++)
		begin
			layer_sr[i] <= layer_sr[i-1];
			field_sr[i] <= field_sr[i-1];
			idx_sr[i] <= idx_sr[i-1];
		end
	end

	// oldest stage meets its data this cycle
	assign wr.wr_en = vld_sr[LAT-1];
	assign wr.layer = layer_sr[LAT-1];
	assign wr.field = field_sr[LAT-1];
	assign wr.word_idx = idx_sr[LAT-1];
	assign wr.data = i_emib_data;

	a_wr_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		wr.wr_en == $past(tag.valid, `CFG_RD_LATENCY))
		else $error("write strobe out of step with read tag");

endmodule

`default_nettype wire

// ==== design/cfg_read_sequencer.sv ====
// FSM that walks the fixed EMIB address table and issues one tagged read per cycle
`default_nettype none

`include "cfg_loader_cfg.svh"

module cfg_read_sequencer import emib_pkg::*, node_cfg_pkg::*; (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_read_flash_done,
	input wire i_config_flag,
	output emib_addr_t o_emib_addr,
	output logic o_rd_ram_en,
	cfg_tag_if.src tag
);

	typedef struct packed {
		emib_addr_t addr;
		layer_e layer;
		field_e field;
		word_idx_t idx;
	} step_t;

	localparam logic [4:0] LAST_STEP = 5'(`CFG_NUM_READS - 1);

	// ************************************************************************
	// read table, one entry per step
	// ************************************************************************

	localparam step_t STEP_TBL [`CFG_NUM_READS] = '{
		'{'h026, L_NODE, F_IP, 2'd0},
		'{'h027, L_NODE, F_IP, 2'd1},
		'{'h02C, L_NODE, F_MAC, 2'd0},
		'{'h02D, L_NODE, F_MAC, 2'd1},
		'{'h02E, L_NODE, F_MAC, 2'd2},
		'{'h033, L_NODE, F_TYPE, 2'd0},
		'{'h034, L_NODE, F_STATE, 2'd0},
		'{'h051, L_UP, F_MACRO, 2'd0},
		'{'h052, L_UP, F_MACRO, 2'd1},
		'{'h053, L_UP, F_REAL, 2'd0},
		'{'h054, L_UP, F_REAL, 2'd1},
		'{'h057, L_UP, F_SEND, 2'd0},
		'{'h058, L_UP, F_SEND, 2'd1},
		'{'h059, L_UP, F_LEN_LOCAL, 2'd0},
		'{'h05C, L_UP, F_LEN_NET, 2'd0},
		'{'h05D, L_DOWN, F_MACRO, 2'd0},
		'{'h05E, L_DOWN, F_MACRO, 2'd1},
		'{'h05F, L_DOWN, F_REAL, 2'd0},
		'{'h060, L_DOWN, F_REAL, 2'd1},
		'{'h061, L_DOWN, F_SEND, 2'd0},
		'{'h062, L_DOWN, F_SEND, 2'd1},
		'{'h063, L_DOWN, F_LEN_LOCAL, 2'd0},
		'{'h066, L_DOWN, F_LEN_NET, 2'd0}
	};

	seq_state_e state_q, state_d;
	logic [4:0] step_q;
	logic start;
	step_t cur_q;             // entry on the bus this cycle

	assign start = i_read_flash_done && i_config_flag;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_IDLE: if (start) state_d = S_READ;
			S_READ: if (step_q == LAST_STEP) state_d = S_DONE;
			S_DONE: state_d = S_IDLE;   // one cycle, then may reload
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state_q <= S_IDLE;
			step_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == S_READ)
				step_q <= (step_q == LAST_STEP) ? 5'd0 : step_q + 5'd1;
		end
	end

	// bus outputs lag the state by one cycle
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_rd_ram_en <= 1'b0;
			o_emib_addr <= '0;
			tag.valid <= 1'b0;
			tag.last <= 1'b0;
		end
		else if (state_q == S_READ)
		begin
			o_rd_ram_en <= 1'b1;
			o_emib_addr <= STEP_TBL[step_q].addr;
			tag.valid <= 1'b1;
			tag.last <= (step_q == LAST_STEP);
		end
		else
		begin
			o_rd_ram_en <= 1'b0;
			o_emib_addr <= '0;     // address parks at zero
			tag.valid <= 1'b0;
			tag.last <= 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		cur_q <= STEP_TBL[step_q];
	end

	assign tag.layer = cur_q.layer;
	assign tag.field = cur_q.field;
	assign tag.word_idx = cur_q.idx;

	a_burst_len: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_ram_en [*`CFG_NUM_READS] |=> !o_rd_ram_en)
		else $error("read burst longer than %0d cycles", `CFG_NUM_READS);

	a_addr_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_rd_ram_en |-> o_emib_addr != '0)
		else $error("read issued to address zero");

endmodule

`default_nettype wire

// ==== design/cfg_wr_if.sv ====
// captured EMIB word with its destination, broadcast from the tracker to the field registers
`default_nettype none

interface cfg_wr_if import emib_pkg::*, node_cfg_pkg::*; ();

	logic wr_en;
	layer_e layer;        // selects the receiving register block
	field_e field;
	word_idx_t word_idx;
	emib_word_t data;

	// receivers always accept, so no ready
	modport src (
		output wr_en, layer, field, word_idx, data
	);

	modport dst (
		input wr_en, layer, field, word_idx, data
	);

endinterface

`default_nettype wire

// ==== design/cfg_tag_if.sv ====
// tag of each EMIB read in flight, passed from the read sequencer to the tracker
`default_nettype none

interface cfg_tag_if import emib_pkg::*, node_cfg_pkg::*; ();

	logic valid;          // same cycles as o_rd_ram_en
	layer_e layer;
	field_e field;
	word_idx_t word_idx;
	logic last;           // final read of the load

	modport src (
		output valid, layer, field, word_idx, last
	);

	modport dst (
		input valid, layer, field, word_idx, last
	);

endinterface

`default_nettype wire

// ==== design/node_cfg_pkg.sv ====
// types for the decoded node configuration and the loader FSM, imported by the RTL
`default_nettype none

`include "cfg_loader_cfg.svh"

package node_cfg_pkg;

	// ************************************************************************
	// value types, built from whole EMIB words
	// ************************************************************************

	typedef logic [2*`CFG_WORD_SZ-1:0] ip_t;    // IPv4 address
	typedef logic [3*`CFG_WORD_SZ-1:0] mac_t;   // MAC address
	typedef logic [2*`CFG_WORD_SZ-1:0] time_t;  // cycle or offset time
	typedef logic [`CFG_WORD_SZ-1:0] len_t;     // data length in 16-bit words

	// owner of a field
	typedef enum logic [1:0] {
		L_NODE,
		L_UP,
		L_DOWN
	} layer_e;

	// item within the owner
	typedef enum logic [3:0] {
		F_IP,
		F_MAC,
		F_TYPE,
		F_STATE,
		F_MACRO,
		F_REAL,
		F_SEND,
		F_LEN_LOCAL,
		F_LEN_NET
	} field_e;

	// read sequencer FSM
	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_DONE
	} seq_state_e;

endpackage

`default_nettype wire

// ==== design/emib_pkg.sv ====
// memory-side types of the EMIB read port, imported by the loader modules and interfaces
`default_nettype none

`include "cfg_loader_cfg.svh"

package emib_pkg;

	// word address presented with the read enable
	typedef logic [`CFG_ADDR_SZ-1:0] emib_addr_t;

	// one data word as returned by the memory
	typedef logic [`CFG_WORD_SZ-1:0] emib_word_t;

	// position of a word inside a multi-word field
	// 0 is read first and lands in the top slot
	typedef logic [1:0] word_idx_t;

endpackage

`default_nettype wire

// ==== design/cfg_loader_cfg.svh ====
// widths, read latency and reset values shared by the loader RTL and its testbench
`ifndef CFG_LOADER_CFG_SVH
`define CFG_LOADER_CFG_SVH

// ************************************************************************
// EMIB bus
// ************************************************************************

`define CFG_ADDR_SZ 10             // word address into EMIB
`define CFG_WORD_SZ 16             // one EMIB data word
`define CFG_RD_LATENCY 3           // cycles from address to data

// ************************************************************************
// load sequence
// ************************************************************************

`define CFG_NUM_READS 23           // reads in one load

// ************************************************************************
// field reset values, all others clear to zero
// ************************************************************************

`define CFG_MACRO_DEFAULT 32'h000F4240
`define CFG_REAL_DEFAULT 32'h000C3500
`define CFG_SEND_DEFAULT 32'h0003E800

// up layer only
`define CFG_UP_LEN_LOCAL_DEFAULT 16'h0020

`endif
